//--- logic/mdc_timer.sv
/*
 * MDC clock divider; also gives a one-cycle bit strobe just before each MDC falling edge
 */
`timescale 1ns/100ps
`include "mdio_params.svh"

module mdc_timer (
	input  logic	i_clk,
	input  logic	i_reset,
	output logic	o_mdc,
	output logic	o_bit_stb
);

	localparam int W = `MDIO_CLK_BITS;

	// Counter value one clock ahead of the all-ones state
	localparam logic [W-1:0] CNT_PRE = {{(W-1){1'b1}}, 1'b0};

	logic [W-1:0]	cnt;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			cnt <= '0;
			o_bit_stb <= 1'b0;
		end
		else
		begin
			cnt <= cnt + 1'b1;
			// High while cnt is all ones, so MDC falls at the next edge
			o_bit_stb <= (cnt == CNT_PRE);
		end
	end

	assign o_mdc = cnt[W-1];

endmodule

//--- logic/mdio_bus_port.sv
/*
 * Wishbone slave side of the MDIO controller. Holds one request for the sequencer,
 * stalls the bus while it is busy and acks once the frame has ended.
 */
`timescale 1ns/100ps
`include "mdio_params.svh"

module mdio_bus_port (
	input  logic				i_clk,
	input  logic				i_reset,
	input  logic				i_wb_cyc,
	input  logic				i_wb_stb,
	input  logic				i_wb_we,
	input  logic [`MDIO_REG_AW-1:0]		i_wb_addr,
	input  logic [`MDIO_DW-1:0]		i_wb_data,
	output logic				o_wb_stall,
	output logic				o_wb_ack,
	input  logic				i_ready,
	input  logic				i_req_done,
	output logic				o_req_valid,
	output mdio_pkg::mdio_req_t		o_req
);

	logic			pending;
	logic			cyc_held;
	logic			accept;
	mdio_pkg::mdio_req_t	req_q;

	assign accept = i_wb_stb && !o_wb_stall;

	// Busy until the cycle after ack
	assign o_wb_stall = !i_ready || pending || o_wb_ack;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (i_req_done)
			pending <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (accept)
		begin
			req_q.wr <= i_wb_we;
			req_q.addr <= i_wb_addr;
			req_q.data <= i_wb_data;
		end
	end

	////////////////////
	// Ack only if the master kept cyc up for the whole transaction
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !i_wb_cyc)
			cyc_held <= 1'b0;
		else if (accept)
			cyc_held <= 1'b1;
		else if (i_req_done)
			cyc_held <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_wb_ack <= 1'b0;
		else
			o_wb_ack <= i_req_done && cyc_held && i_wb_cyc;
	end

	assign o_req_valid = pending;
	assign o_req = req_q;

endmodule

//--- logic/mdio_ctrl_top.sv
/*
 * MDIO management controller: Wishbone port, MDC timer and frame sequencer
 */
`timescale 1ns/100ps
`include "mdio_params.svh"

module mdio_ctrl_top (
	input  logic				i_clk,
	input  logic				i_reset,
	input  logic				i_wb_cyc,
	input  logic				i_wb_stb,
	input  logic				i_wb_we,
	input  logic [`MDIO_REG_AW-1:0]		i_wb_addr,
	input  logic [`MDIO_DW-1:0]		i_wb_data,
	output logic				o_wb_stall,
	output logic				o_wb_ack,
	output logic [`MDIO_DW-1:0]		o_wb_data,
	output logic				o_mdc,
	output logic				o_mdio,
	output logic				o_mdwe,
	input  logic				i_mdio
);

	logic			bit_stb;
	logic			req_valid;
	logic			req_done;
	logic			seq_ready;
	mdio_pkg::mdio_req_t	req;

	mdc_timer u_timer (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.o_mdc		(o_mdc),
		.o_bit_stb	(bit_stb)
	);

	mdio_bus_port u_port (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_wb_cyc	(i_wb_cyc),
		.i_wb_stb	(i_wb_stb),
		.i_wb_we	(i_wb_we),
		.i_wb_addr	(i_wb_addr),
		.i_wb_data	(i_wb_data),
		.o_wb_stall	(o_wb_stall),
		.o_wb_ack	(o_wb_ack),
		.i_ready	(seq_ready),
		.i_req_done	(req_done),
		.o_req_valid	(req_valid),
		.o_req		(req)
	);

	// Read data comes straight from the receive shift register
	mdio_sequencer u_seq (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_bit_stb	(bit_stb),
		.i_req_valid	(req_valid),
		.i_req		(req),
		.o_ready	(seq_ready),
		.o_req_done	(req_done),
		.o_rd_data	(o_wb_data),
		.o_mdio		(o_mdio),
		.o_mdwe		(o_mdwe),
		.i_mdio		(i_mdio)
	);

endmodule

//--- logic/mdio_params.svh
/*
 * Build-time constants for the MDIO controller, included by the RTL and the testbench
 */
`ifndef MDIO_PARAMS_SVH
`define MDIO_PARAMS_SVH

// MDC period is 2**MDIO_CLK_BITS system clocks
`define MDIO_CLK_BITS	3

// Address of the PHY placed in every frame
`define MDIO_PHY_ADDR	5'd1

// MDC periods with the line held high after reset
`define MDIO_RESET_BITS	64

`define MDIO_REG_AW	5
`define MDIO_DW		16

`endif

//--- logic/mdio_pkg.sv
/*
 * Shared types for the MDIO controller: sequencer states, frame opcodes and the request
 */
`include "mdio_params.svh"

package mdio_pkg;

	////////////////////
	// Sequencer states
	typedef enum logic [2:0] {
		ST_RESET   = 3'd0,
		ST_IDLE    = 3'd1,
		ST_ADDRESS = 3'd2,
		ST_READ    = 3'd3,
		ST_WRITE   = 3'd4
	} mdio_state_e;

	// Clause 22 opcodes
	typedef enum logic [1:0] {
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10
	} mdio_op_e;

	////////////////////
	// One captured bus request
	typedef struct packed {
		logic				wr;
		logic [`MDIO_REG_AW-1:0]	addr;
		logic [`MDIO_DW-1:0]		data;
	} mdio_req_t;

endpackage

//--- logic/mdio_sequencer.sv
/*
 * MDIO frame FSM. Sends the 16-bit header, then either shifts out write data
 * or releases the line and shifts i_mdio into the read register.
 */
`timescale 1ns/100ps
`include "mdio_params.svh"

module mdio_sequencer (
	input  logic				i_clk,
	input  logic				i_reset,
	input  logic				i_bit_stb,
	input  logic				i_req_valid,
	input  mdio_pkg::mdio_req_t		i_req,
	output logic				o_ready,
	output logic				o_req_done,
	output logic [`MDIO_DW-1:0]		o_rd_data,
	output logic				o_mdio,
	output logic				o_mdwe,
	input  logic				i_mdio
);

	// Wide enough for the reset count and a 16-bit half frame
	localparam int CNT_W = ($clog2(`MDIO_RESET_BITS) > 5) ? $clog2(`MDIO_RESET_BITS) : 5;

	mdio_pkg::mdio_state_e	state;
	mdio_pkg::mdio_op_e	op;
	logic [CNT_W-1:0]	bit_cnt;
	logic [`MDIO_DW-1:0]	tx_sr;
	logic [`MDIO_DW-1:0]	header;
	logic [1:0]		turnaround;

	////////////////////
	// Header word: start, opcode, PHY, register, turnaround
	always_comb
	begin
		op = i_req.wr ? mdio_pkg::OP_WRITE : mdio_pkg::OP_READ;
		// Reads leave the turnaround to the PHY
		turnaround = i_req.wr ? 2'b10 : 2'b11;
		header = {2'b01, op, `MDIO_PHY_ADDR, i_req.addr, turnaround};
	end

	assign o_ready = (state == mdio_pkg::ST_IDLE);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= mdio_pkg::ST_RESET;
			bit_cnt <= CNT_W'(`MDIO_RESET_BITS - 1);
			o_mdio <= 1'b1;
			o_mdwe <= 1'b1;
			o_req_done <= 1'b0;
		end
		else
		begin
			o_req_done <= 1'b0;
			case (state)
			mdio_pkg::ST_RESET:
			begin
				o_mdio <= 1'b1;
				o_mdwe <= 1'b1;
				if (i_bit_stb)
				begin
					bit_cnt <= bit_cnt - 1'b1;
					if (bit_cnt == '0)
						state <= mdio_pkg::ST_IDLE;
				end
			end
			mdio_pkg::ST_IDLE:
			begin
				// First frame bit goes out at the next MDC fall
				if (i_bit_stb && i_req_valid)
				begin
					o_mdio <= header[`MDIO_DW-1];
					bit_cnt <= CNT_W'(`MDIO_DW - 1);
					state <= mdio_pkg::ST_ADDRESS;
				end
			end
			mdio_pkg::ST_ADDRESS:
			begin
				if (i_bit_stb)
				begin
					bit_cnt <= bit_cnt - 1'b1;
					o_mdio <= tx_sr[`MDIO_DW-1];
					// Release for the turnaround on a read
					if (!i_req.wr && bit_cnt == CNT_W'(2))
						o_mdwe <= 1'b0;
					if (bit_cnt == '0)
					begin
						o_mdio <= i_req.wr ? i_req.data[`MDIO_DW-1] : 1'b1;
						bit_cnt <= CNT_W'(`MDIO_DW - 1);
						state <= i_req.wr ? mdio_pkg::ST_WRITE : mdio_pkg::ST_READ;
					end
				end
			end
			mdio_pkg::ST_READ, mdio_pkg::ST_WRITE:
			begin
				if (i_bit_stb)
				begin
					bit_cnt <= bit_cnt - 1'b1;
					o_mdio <= tx_sr[`MDIO_DW-1];
					if (bit_cnt == '0)
					begin
						o_mdio <= 1'b1;
						o_mdwe <= 1'b1;
						o_req_done <= 1'b1;
						state <= mdio_pkg::ST_IDLE;
					end
				end
			end
			default:
			begin
				bit_cnt <= CNT_W'(`MDIO_RESET_BITS - 1);
				state <= mdio_pkg::ST_RESET;
			end
			endcase
		end
	end

	////////////////////
	// Shift registers
	always_ff @(posedge i_clk)
	begin
		if (i_bit_stb)
		begin
			tx_sr <= {tx_sr[`MDIO_DW-2:0], 1'b1};
			if (state == mdio_pkg::ST_IDLE)
				tx_sr <= {header[`MDIO_DW-2:0], 1'b1};
			else if (state == mdio_pkg::ST_ADDRESS && bit_cnt == '0)
				tx_sr <= i_req.wr ? {i_req.data[`MDIO_DW-2:0], 1'b1} : '1;
		end
	end

	// PHY drives on MDC rise, sampled here at the fall
	always_ff @(posedge i_clk)
	begin
		if (i_bit_stb && state == mdio_pkg::ST_READ)
			o_rd_data <= {o_rd_data[`MDIO_DW-2:0], i_mdio};
	end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module mdio_tb -f sim.f -o mdio_sim

sim_out=$(./obj_dir/mdio_sim 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "TEST RESULT: PASS"; then
	exit 0
else
	exit 1
fi

//--- sim.f
+incdir+logic
logic/mdio_pkg.sv
logic/mdc_timer.sv
logic/mdio_bus_port.sv
logic/mdio_sequencer.sv
logic/mdio_ctrl_top.sv
testbench/mdio_chk.sv
testbench/mdio_tb.sv

//--- testbench/mdio_cases.txt
# op addr data. w write, r read with expected data, m read checked against the PHY model
# x write during which the master drops cyc
w 03 a5c3
r 03 a5c3
m 07 0000
w 1f 0001
x 04 beef
r 04 beef
m 12 0000
w 00 ffff
r 1f 0001
r 00 ffff

//--- testbench/mdio_chk.sv
/*
 * Protocol assertions on the Wishbone and MDIO side that are bound to the controller top level
 */
`timescale 1ns/100ps

module mdio_chk (
	input logic	i_clk,
	input logic	i_reset,
	input logic	o_wb_ack,
	input logic	o_wb_stall,
	input logic	o_mdc,
	input logic	o_mdio
);

	// Ack is a single-cycle pulse
	ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_ack |=> !o_wb_ack)
		else $error("ack held for more than one cycle");

	// Bus is free again in the cycle after ack
	stall_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_ack |=> !o_wb_stall)
		else $error("stall still high in the cycle after ack");

	// Data line moves only together with an MDC falling edge
	mdio_on_fall: assert property (@(posedge i_clk) disable iff (i_reset)
		$changed(o_mdio) |-> $fell(o_mdc))
		else $error("mdio changed away from an MDC falling edge");

	stall_after_reset: assert property (@(posedge i_clk)
		$fell(i_reset) |-> o_wb_stall)
		else $error("stall low right after reset");

endmodule

bind mdio_ctrl_top mdio_chk u_chk (
	.i_clk		(i_clk),
	.i_reset	(i_reset),
	.o_wb_ack	(o_wb_ack),
	.o_wb_stall	(o_wb_stall),
	.o_mdc		(o_mdc),
	.o_mdio		(o_mdio)
);

//--- testbench/mdio_tb.sv
/*
 * Testbench for the MDIO controller that runs the cases file against a PHY model on the line
 */
`timescale 1ns/100ps
`include "mdio_params.svh"

module mdio_tb;

	localparam int CLK_NS = 10;
	localparam int MDC_NS = (1 << `MDIO_CLK_BITS) * CLK_NS;
	localparam int MDC_CLKS = 1 << `MDIO_CLK_BITS;

	logic i_clk, i_reset, i_wb_cyc, i_wb_stb, i_wb_we, i_mdio;
	logic [`MDIO_REG_AW-1:0] i_wb_addr;
	logic [`MDIO_DW-1:0] i_wb_data;
	logic o_wb_stall, o_wb_ack, o_mdc, o_mdio, o_mdwe;
	logic [`MDIO_DW-1:0] o_wb_data;

	// PHY model state
	logic [`MDIO_DW-1:0] phy_regs [32];
	logic mdc_q, in_frame, is_read, rd_mdwe_bad;
	int unsigned bit_n, frames;
	logic [15:0] hdr_sr, wdat_sr, last_hdr;

	byte case_op[$];
	logic [4:0] case_addr[$];
	logic [15:0] case_data[$];
	int n_cases = 0;

	mdio_ctrl_top dut (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_NS / 2) i_clk = ~i_clk;
	end

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input int exp, input int act);
		report_failure($sformatf("error %s: expected %h, actual %h", name, exp, act));
	endtask

	////////////////////
	// PHY model that decodes at each MDC rise
	always @(posedge i_clk)
	begin
		mdc_q <= o_mdc;
		if (i_reset)
		begin
			in_frame <= 1'b0;
			frames <= 0;
			i_mdio <= 1'b1;
		end
		else if (o_mdc && !mdc_q)
		begin
			if (!in_frame)
			begin
				// Line released between frames
				i_mdio <= 1'b1;
				// Start bit 0 after the idle ones
				if (o_mdwe && !o_mdio)
				begin
					in_frame <= 1'b1;
					bit_n <= 1;
					hdr_sr <= 16'h0;
					rd_mdwe_bad <= 1'b0;
				end
			end
			else
			begin
				bit_n <= bit_n + 1;
				if (bit_n < 16)
					hdr_sr <= {hdr_sr[14:0], o_mdio};
				if (bit_n == 4)
					is_read <= (hdr_sr[1:0] == 2'b10);
				if (is_read && bit_n >= 14 && o_mdwe)
					rd_mdwe_bad <= 1'b1;
				if (bit_n >= 16)
				begin
					wdat_sr <= {wdat_sr[14:0], o_mdio};
					if (is_read)
						i_mdio <= phy_regs[hdr_sr[6:2]][31 - bit_n];
				end
				if (bit_n == 31)
				begin
					in_frame <= 1'b0;
					frames <= frames + 1;
					last_hdr <= hdr_sr;
					if (!is_read)
						phy_regs[hdr_sr[6:2]] <= {wdat_sr[14:0], o_mdio};
				end
			end
		end
	end

	task automatic run_case(input byte op, input logic [4:0] addr, input logic [15:0] data,
		input string name);
		int unsigned frames0;
		logic [15:0] exp_hdr;
		logic [15:0] exp_rd;
		logic wr;
		wr = (op == "w" || op == "x");
		frames0 = frames;
		do @(posedge i_clk); while (o_wb_stall);
		i_wb_cyc <= 1'b1;
		i_wb_stb <= 1'b1;
		i_wb_we <= wr;
		i_wb_addr <= addr;
		i_wb_data <= data;
		do @(posedge i_clk); while (o_wb_stall);
		// Keep stb up while stalled, which must not start a second frame
		i_wb_addr <= addr + 5'd1;
		repeat (3) @(posedge i_clk);
		i_wb_stb <= 1'b0;
		if (op == "x")
		begin
			i_wb_cyc <= 1'b0;
			do
			begin
				@(posedge i_clk);
				assert (!o_wb_ack)
					else report_failure({name, ": ack given after cyc dropped"});
			end
			while (o_wb_stall);
		end
		else
		begin
			do @(posedge i_clk); while (!o_wb_ack);
			exp_rd = (op == "m") ? phy_regs[addr] : data;
			if (!wr)
				assert (o_wb_data == exp_rd)
					else report_mismatch({name, " read data"}, exp_rd, o_wb_data);
			i_wb_cyc <= 1'b0;
		end
		assert (frames == frames0 + 1) else report_mismatch({name, " frames"}, frames0 + 1, frames);
		exp_hdr = {2'b01, wr ? 2'b01 : 2'b10, `MDIO_PHY_ADDR, addr, 2'b10};
		if (wr)
		begin
			assert (last_hdr == exp_hdr) else report_mismatch({name, " header"}, exp_hdr, last_hdr);
			assert (phy_regs[addr] == data)
				else report_mismatch({name, " PHY reg"}, data, phy_regs[addr]);
		end
		else
		begin
			assert (last_hdr[15:2] == exp_hdr[15:2])
				else report_mismatch({name, " header"}, exp_hdr[15:2], last_hdr[15:2]);
			assert (!rd_mdwe_bad) else report_failure({name, ": line still driven during read"});
		end
	endtask

	initial
	begin
		wait (n_cases > 0);
		#((n_cases * 40 + `MDIO_RESET_BITS) * MDC_NS);
		report_failure("timeout: the cases did not finish in time");
	end

	initial
	begin
		int fd;
		int n_idle;
		string line;
		byte op;
		logic [4:0] addr;
		logic [15:0] data;
		i_reset = 1'b1;
		i_wb_cyc = 1'b0;
		i_wb_stb = 1'b0;
		i_wb_we = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_mdio = 1'b1;
		void'($urandom(32'h9366a4b7));
		for (int i = 0; i < 32; i++)
			phy_regs[i] = 16'($urandom);
		fd = $fopen("testbench/mdio_cases.txt", "r");
		assert (fd != 0) else report_failure("cannot open the cases file");
		while ($fgets(line, fd))
		begin
			if (line.len() > 2 && line[0] != "#")
			begin
				void'($sscanf(line, "%c %h %h", op, addr, data));
				case_op.push_back(op);
				case_addr.push_back(addr);
				case_data.push_back(data);
			end
		end
		$fclose(fd);
		n_cases = case_op.size();
		assert (n_cases > 0) else report_failure("no cases found in the cases file");
		repeat (5) @(posedge i_clk);
		i_reset <= 1'b0;
		// Line held high and bus stalled for the reset preamble
		n_idle = 0;
		do
		begin
			@(posedge i_clk);
			assert (o_mdio && o_mdwe) else report_failure("line not held high after reset");
			n_idle++;
		end
		while (o_wb_stall);
		assert (n_idle >= (`MDIO_RESET_BITS - 1) * MDC_CLKS
			&& n_idle <= (`MDIO_RESET_BITS + 1) * MDC_CLKS)
			else report_mismatch("reset length", `MDIO_RESET_BITS * MDC_CLKS, n_idle);
		for (int i = 0; i < n_cases; i++)
			run_case(case_op[i], case_addr[i], case_data[i], $sformatf("case %0d", i));
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
